//--- sim.f
rtl/i3c_pkg.sv
rtl/bus_if.sv
rtl/bus_monitor.sv
rtl/byte_receiver.sv
rtl/sda_driver.sv
rtl/target_fsm.sv
rtl/controller.sv
tb/tb_controller.sv

//--- Makefile
SIM        ?= verilator
TOP        ?= tb_controller
FILELIST   ?= sim.f
FLAGS      ?= --binary --timing --timescale 1ns/1ps --top-module $(TOP)
LINT_FLAGS ?= --lint-only --timing --timescale 1ns/1ps -Wall --top-module $(TOP)
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "STATUS: PASS" $(LOG)

lint:
	$(SIM) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb/tb_controller.sv
//--------------------------------------------------
// Testbench for the target bus path. An open-drain
// master bit-bangs a table of transactions and the
// DUT's conditions, ACKs and bytes are checked.
//--------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_controller;

  localparam int NROWS = 7;
  localparam int WATCHDOG_CYCLES = (NROWS + 1) * 12 * 9 * 16 * 2;

  typedef struct packed {
    logic            rep;        // opens with repeated START
    logic [7:0]      addr;
    int              ndata;
    logic [5:0][7:0] data;
    logic            hold_ready;
    logic            addr_ack;
    int              n_ack;      // data bytes expected to be ACKed
    logic            rand_fill;
  } row_t;

  logic        clk_i;
  logic        rst_n_i;
  logic        scl_m;
  logic        sda_m;
  logic        sda_o;
  logic        sda_line;
  logic [19:0] t_hd_dat;
  logic        fsm_en;
  logic [6:0]  target_addr;
  logic        target_addr_valid;
  logic        bus_start;
  logic        bus_rstart;
  logic        bus_stop;
  logic [7:0]  bus_addr;
  logic        bus_addr_valid;
  logic [7:0]  rx_data;
  logic        rx_valid;
  logic        rx_ready;
  logic        fsm_idle;
  logic        xfer_in_progress;

  row_t        rows [NROWS];
  logic [7:0]  got_addr[$];
  logic [7:0]  exp_addr[$];
  logic [7:0]  got_rx[$];
  logic [7:0]  exp_rx[$];
  int          got_start;
  int          got_rstart;
  int          got_stop;
  int          exp_start;
  int          exp_rstart;
  int          exp_stop;
  logic        held_q;
  logic [7:0]  held_data;
  int          checks;
  int          errors;
  integer      seed;

  // Open-drain line
  assign sda_line = sda_m & sda_o;

  controller #(
    .FILTER_CYCLES (2)
  ) dut (
    .clk_i               (clk_i),
    .rst_n_i             (rst_n_i),
    .scl_i               (scl_m),
    .sda_i               (sda_line),
    .sda_o               (sda_o),
    .t_hd_dat_i          (t_hd_dat),
    .fsm_en_i            (fsm_en),
    .target_addr_i       (target_addr),
    .target_addr_valid_i (target_addr_valid),
    .bus_start_o         (bus_start),
    .bus_rstart_o        (bus_rstart),
    .bus_stop_o          (bus_stop),
    .bus_addr_o          (bus_addr),
    .bus_addr_valid_o    (bus_addr_valid),
    .rx_data_o           (rx_data),
    .rx_valid_o          (rx_valid),
    .rx_ready_i          (rx_ready),
    .fsm_idle_o          (fsm_idle),
    .xfer_in_progress_o  (xfer_in_progress)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR t=%0t %s got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  // Outputs sampled at the falling clock edge
  task automatic sample_outputs();
    if (bus_start) got_start++;
    if (bus_rstart) got_rstart++;
    if (bus_stop) got_stop++;
    if (bus_addr_valid) got_addr.push_back(bus_addr);
    if (held_q) begin
      check("rx_valid_o", 32'(rx_valid), 32'(1'b1));
      check("rx_data_o", 32'(rx_data), 32'(held_data));
    end
    if (rx_valid && rx_ready) got_rx.push_back(rx_data);
    held_q    = rx_valid && !rx_ready;
    held_data = rx_data;
    if (!fsm_en) check("sda_o", 32'(sda_o), 32'(1'b1));
  endtask

  task automatic tick();
    @(negedge clk_i);
    sample_outputs();
    @(posedge clk_i);
    #2;
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) tick();
  endtask

  // Bit period of 16 cycles with SDA moving 3 cycles into the low phase
  task automatic send_bit(input logic b);
    wait_cycles(3);
    sda_m = b;
    wait_cycles(7);
    scl_m = 1'b1;
    wait_cycles(6);
    scl_m = 1'b0;
  endtask

  task automatic send_byte(input logic [7:0] b);
    for (int i = 7; i >= 0; i--) send_bit(b[i]);
  endtask

  task automatic read_ack(output logic ack);
    logic s1;
    logic s2;
    wait_cycles(3);
    sda_m = 1'b1;
    wait_cycles(7);
    scl_m = 1'b1;
    wait_cycles(1);
    s1 = sda_line;
    wait_cycles(4);
    s2 = sda_line;
    wait_cycles(1);
    scl_m = 1'b0;
    check("SDA stable in ACK bit", 32'(s2), 32'(s1));
    ack = !s1 && !s2;
  endtask

  task automatic start_bus();
    sda_m = 1'b0;
    exp_start++;
    wait_cycles(8);
    scl_m = 1'b0;
  endtask

  task automatic restart_bus();
    wait_cycles(3);
    sda_m = 1'b1;
    wait_cycles(7);
    scl_m = 1'b1;
    wait_cycles(6);
    sda_m = 1'b0;
    exp_rstart++;
    wait_cycles(8);
    scl_m = 1'b0;
  endtask

  task automatic stop_bus();
    wait_cycles(3);
    sda_m = 1'b0;
    wait_cycles(7);
    scl_m = 1'b1;
    wait_cycles(6);
    sda_m = 1'b1;
    exp_stop++;
    wait_cycles(8);
  endtask

  task automatic compare_results();
    check("bus_start_o pulses", 32'(got_start), 32'(exp_start));
    check("bus_rstart_o pulses", 32'(got_rstart), 32'(exp_rstart));
    check("bus_stop_o pulses", 32'(got_stop), 32'(exp_stop));
    check("bus_addr_valid_o pulses", 32'(got_addr.size()), 32'(exp_addr.size()));
    check("rx transfers", 32'(got_rx.size()), 32'(exp_rx.size()));
    for (int i = 0; i < exp_addr.size() && i < got_addr.size(); i++) begin
      check("bus_addr_o", 32'(got_addr[i]), 32'(exp_addr[i]));
    end
    for (int i = 0; i < exp_rx.size() && i < got_rx.size(); i++) begin
      check("rx_data_o", 32'(got_rx[i]), 32'(exp_rx[i]));
    end
  endtask

  task automatic release_held(input logic [7:0] first);
    int limit;
    check("rx_valid_o while held", 32'(rx_valid), 32'(1'b1));
    check("rx_data_o while held", 32'(rx_data), 32'(first));
    exp_rx.push_back(first);
    rx_ready = 1'b1;
    limit = 0;
    while (got_rx.size() < exp_rx.size() && limit < 100) begin
      tick();
      limit++;
    end
    if (got_rx.size() < exp_rx.size()) begin
      errors++;
      $display("Held byte was not transferred within 100 cycles after rx_ready_i rose");
    end
    wait_cycles(4);
    compare_results();
  endtask

  task automatic run_row(input row_t row, input logic stop_after);
    logic ack;
    int   k;
    rx_ready = !row.hold_ready;
    if (row.rep) begin
      restart_bus();
    end else begin
      start_bus();
    end
    send_byte(row.addr);
    exp_addr.push_back(row.addr);
    read_ack(ack);
    check("address ACK", 32'(ack), 32'(row.addr_ack));
    check("xfer_in_progress_o after address", 32'(xfer_in_progress), 32'(row.addr_ack));
    k = 0;
    // Master gives up on the first NACK
    while (ack && k < row.ndata) begin
      send_byte(row.data[k]);
      read_ack(ack);
      check("data ACK", 32'(ack), 32'(k < row.n_ack));
      if (ack && !row.hold_ready) exp_rx.push_back(row.data[k]);
      k++;
    end
    if (stop_after) stop_bus();
    wait_cycles(12);
    compare_results();
    check("fsm_idle_o after row", 32'(fsm_idle), 32'(stop_after));
    check("xfer_in_progress_o after row", 32'(xfer_in_progress), 32'(!stop_after && ack));
    if (row.hold_ready) release_held(row.data[0]);
  endtask

  task automatic disabled_write();
    logic ack;
    fsm_en = 1'b0;
    start_bus();
    send_byte(8'h54);
    read_ack(ack);
    check("ACK while disabled", 32'(ack), 32'(1'b0));
    stop_bus();
    wait_cycles(12);
    compare_results();
    check("fsm_idle_o", 32'(fsm_idle), 32'(1'b1));
    check("xfer_in_progress_o while disabled", 32'(xfer_in_progress), 32'(1'b0));
    fsm_en = 1'b1;
  endtask

  function automatic row_t make_row(input logic rep, input logic [7:0] addr, input int ndata,
                                    input logic [47:0] data, input logic hold_ready,
                                    input logic addr_ack, input int n_ack,
                                    input logic rand_fill);
    row_t row;
    row.rep        = rep;
    row.addr       = addr;
    row.ndata      = ndata;
    row.data       = data;
    row.hold_ready = hold_ready;
    row.addr_ack   = addr_ack;
    row.n_ack      = n_ack;
    row.rand_fill  = rand_fill;
    return row;
  endfunction

  initial begin
    logic stop_after;
    scl_m             = 1'b1;
    sda_m             = 1'b1;
    rst_n_i           = 1'b0;
    t_hd_dat          = 20'd3;
    fsm_en            = 1'b0;
    target_addr       = 7'h2A;
    target_addr_valid = 1'b1;
    rx_ready          = 1'b1;
    held_q            = 1'b0;
    seed              = 32'h8660;

    // rep, addr, ndata, data, hold ready, addr ACK, data ACKs, random fill
    rows[0] = make_row(1'b0, 8'h54, 3, 48'h0000_00C3_5A01, 1'b0, 1'b1, 3, 1'b0);
    rows[1] = make_row(1'b0, 8'h56, 2, 48'h0000_0000_1122, 1'b0, 1'b0, 0, 1'b0);
    rows[2] = make_row(1'b0, 8'h55, 1, 48'h0000_0000_0033, 1'b0, 1'b0, 0, 1'b0);
    rows[3] = make_row(1'b0, 8'h54, 1, 48'h0000_0000_00A5, 1'b0, 1'b1, 1, 1'b0);
    rows[4] = make_row(1'b1, 8'h54, 4, 48'h0, 1'b0, 1'b1, 4, 1'b1);
    rows[5] = make_row(1'b0, 8'h54, 2, 48'h0000_0000_B7E4, 1'b1, 1'b1, 1, 1'b0);
    rows[6] = make_row(1'b0, 8'h54, 6, 48'h0, 1'b0, 1'b1, 6, 1'b1);
    for (int r = 0; r < NROWS; r++) begin
      if (rows[r].rand_fill) begin
        for (int k = 0; k < 6; k++) rows[r].data[k] = 8'($random(seed));
      end
    end

    repeat (10) @(posedge clk_i);
    #2;
    rst_n_i = 1'b1;
    wait_cycles(4);
    check("sda_o after reset", 32'(sda_o), 32'(1'b1));
    check("fsm_idle_o after reset", 32'(fsm_idle), 32'(1'b1));
    check("rx_valid_o after reset", 32'(rx_valid), 32'(1'b0));
    check("bus_addr_valid_o after reset", 32'(bus_addr_valid), 32'(1'b0));

    disabled_write();
    for (int r = 0; r < NROWS; r++) begin
      stop_after = (r == NROWS - 1) || !rows[r + 1].rep;
      run_row(rows[r], stop_after);
    end

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("Watchdog expired after %0d cycles, the run did not complete", WATCHDOG_CYCLES);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- rtl/controller.sv
//-------------------------------------------------
// Top level of the target bus path. Pins in, ACK
// on sda_o, received bytes out on valid/ready.
//-------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module controller #(
  parameter int unsigned FILTER_CYCLES = i3c_pkg::FILTER_CYCLES_DEFAULT
) (
  input  logic               clk_i,
  input  logic               rst_n_i,

  input  logic               scl_i,
  input  logic               sda_i,
  output logic               sda_o,

  input  i3c_pkg::hold_cnt_t t_hd_dat_i,
  input  logic               fsm_en_i,
  input  i3c_pkg::addr7_t    target_addr_i,
  input  logic               target_addr_valid_i,

  output logic               bus_start_o,
  output logic               bus_rstart_o,
  output logic               bus_stop_o,
  output i3c_pkg::bus_byte_t bus_addr_o,
  output logic               bus_addr_valid_o,

  output i3c_pkg::bus_byte_t rx_data_o,
  output logic               rx_valid_o,
  input  logic               rx_ready_i,

  output logic               fsm_idle_o,
  output logic               xfer_in_progress_o
);

  bus_if bus_conn ();

  i3c_pkg::bus_byte_t frame_byte;
  logic               byte_done;
  logic               ack_slot;
  logic               capture;
  logic               ack_req;

  bus_monitor #(
    .FILTER_CYCLES (FILTER_CYCLES)
  ) u_bus_monitor (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .scl_i   (scl_i),
    .sda_i   (sda_i),
    .bus     (bus_conn.mon)
  );

  byte_receiver u_byte_receiver (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .bus          (bus_conn.sink),
    .capture_i    (capture),
    .frame_byte_o (frame_byte),
    .byte_done_o  (byte_done),
    .ack_slot_o   (ack_slot),
    .rx_data_o    (rx_data_o),
    .rx_valid_o   (rx_valid_o),
    .rx_ready_i   (rx_ready_i)
  );

  sda_driver u_sda_driver (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .bus        (bus_conn.sink),
    .ack_req_i  (ack_req),
    .t_hd_dat_i (t_hd_dat_i),
    .sda_o      (sda_o)
  );

  target_fsm u_target_fsm (
    .clk_i               (clk_i),
    .rst_n_i             (rst_n_i),
    .bus                 (bus_conn.sink),
    .fsm_en_i            (fsm_en_i),
    .target_addr_i       (target_addr_i),
    .target_addr_valid_i (target_addr_valid_i),
    .frame_byte_i        (frame_byte),
    .byte_done_i         (byte_done),
    .ack_slot_i          (ack_slot),
    .rx_valid_i          (rx_valid_o),
    .capture_o           (capture),
    .ack_req_o           (ack_req),
    .bus_addr_o          (bus_addr_o),
    .bus_addr_valid_o    (bus_addr_valid_o),
    .fsm_idle_o          (fsm_idle_o),
    .xfer_in_progress_o  (xfer_in_progress_o)
  );

  // Condition pulses straight from the monitor
  assign bus_start_o  = bus_conn.start;
  assign bus_rstart_o = bus_conn.rstart;
  assign bus_stop_o   = bus_conn.stop;

endmodule

`default_nettype wire

//--- rtl/target_fsm.sv
//-------------------------------------------------
// Target control FSM: address phase, ACK decision,
// private write data phase, and wait for STOP.
//-------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module target_fsm (
  input  logic               clk_i,
  input  logic               rst_n_i,
  bus_if.sink                bus,
  input  logic               fsm_en_i,
  input  i3c_pkg::addr7_t    target_addr_i,
  input  logic               target_addr_valid_i,
  input  i3c_pkg::bus_byte_t frame_byte_i,
  input  logic               byte_done_i,
  input  logic               ack_slot_i,
  input  logic               rx_valid_i,
  output logic               capture_o,
  output logic               ack_req_o,
  output i3c_pkg::bus_byte_t bus_addr_o,
  output logic               bus_addr_valid_o,
  output logic               fsm_idle_o,
  output logic               xfer_in_progress_o
);

  i3c_pkg::fsm_state_t state_q;
  i3c_pkg::fsm_state_t state_d;
  i3c_pkg::bus_byte_t  bus_addr_q;
  logic                bus_addr_valid_q;
  logic                addr_done;
  logic                addr_match;
  logic                slot_end;

  assign addr_done  = (state_q == i3c_pkg::ST_ADDR) && byte_done_i;
  // Private write to our static address only
  assign addr_match = target_addr_valid_i && !frame_byte_i[0] &&
                      (frame_byte_i[7:1] == target_addr_i);
  assign slot_end   = bus.scl_fall && ack_slot_i;

  always_comb begin
    state_d = state_q;
    if (!fsm_en_i || bus.stop) begin
      state_d = i3c_pkg::ST_IDLE;
    end else if (bus.start || bus.rstart) begin
      state_d = i3c_pkg::ST_ADDR;
    end else begin
      case (state_q)
        i3c_pkg::ST_ADDR: begin
          if (byte_done_i) begin
            state_d = addr_match ? i3c_pkg::ST_ADDR_ACK : i3c_pkg::ST_WAIT_STOP;
          end
        end
        i3c_pkg::ST_ADDR_ACK,
        i3c_pkg::ST_DATA_ACK: begin
          if (slot_end) begin
            state_d = i3c_pkg::ST_DATA;
          end
        end
        i3c_pkg::ST_DATA: begin
          // Holding register still full, so NACK
          if (byte_done_i) begin
            state_d = rx_valid_i ? i3c_pkg::ST_WAIT_STOP : i3c_pkg::ST_DATA_ACK;
          end
        end
        default: begin
          state_d = state_q;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q          <= i3c_pkg::ST_IDLE;
      bus_addr_valid_q <= 1'b0;
    end else begin
      state_q          <= state_d;
      bus_addr_valid_q <= addr_done;
    end
  end

  always_ff @(posedge clk_i) begin
    if (addr_done) begin
      bus_addr_q <= frame_byte_i;
    end
  end

  assign capture_o = (state_q == i3c_pkg::ST_DATA) && byte_done_i && !rx_valid_i;

  // Dropped once the slot is open so the closing fall releases SDA
  assign ack_req_o = ((state_q == i3c_pkg::ST_ADDR_ACK) ||
                      (state_q == i3c_pkg::ST_DATA_ACK)) && !ack_slot_i;

  assign bus_addr_o         = bus_addr_q;
  assign bus_addr_valid_o   = bus_addr_valid_q;
  assign fsm_idle_o         = (state_q == i3c_pkg::ST_IDLE);
  assign xfer_in_progress_o = state_q inside {i3c_pkg::ST_ADDR_ACK, i3c_pkg::ST_DATA,
                                              i3c_pkg::ST_DATA_ACK};

endmodule

`default_nettype wire

//--- rtl/sda_driver.sv
//-------------------------------------------------
// Open-drain SDA output for the ACK bit. Pulls low
// t_hd_dat cycles after SCL falls; 1 = released.
//-------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module sda_driver (
  input  logic               clk_i,
  input  logic               rst_n_i,
  bus_if.sink                bus,
  input  logic               ack_req_i,
  input  i3c_pkg::hold_cnt_t t_hd_dat_i,
  output logic               sda_o
);

  localparam i3c_pkg::hold_cnt_t ONE = i3c_pkg::hold_cnt_t'(1);

  // Nonzero while waiting out the hold time
  i3c_pkg::hold_cnt_t hold_cnt_q;
  logic               drive_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      hold_cnt_q <= '0;
      drive_q    <= 1'b0;
    end else if (bus.start || bus.rstart || bus.stop) begin
      hold_cnt_q <= '0;
      drive_q    <= 1'b0;
    end else if (bus.scl_fall) begin
      if (drive_q || hold_cnt_q != '0) begin
        hold_cnt_q <= '0;
        drive_q    <= 1'b0;
      end else if (ack_req_i) begin
        if (t_hd_dat_i <= ONE) begin
          drive_q <= 1'b1;
        end else begin
          hold_cnt_q <= ONE;
        end
      end
    end else if (hold_cnt_q != '0) begin
      if (bus.scl) begin
        // Clock high again before the hold ran out, give up
        hold_cnt_q <= '0;
      end else if (hold_cnt_q == t_hd_dat_i - ONE) begin
        hold_cnt_q <= '0;
        drive_q    <= 1'b1;
      end else begin
        hold_cnt_q <= hold_cnt_q + ONE;
      end
    end
  end

  assign sda_o = ~drive_q;

endmodule

`default_nettype wire

//--- rtl/byte_receiver.sv
//-------------------------------------------------
// Shifts in 9-bit frames (8 data + ACK) and holds
// one captured data byte behind a valid/ready pair.
//-------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module byte_receiver (
  input  logic               clk_i,
  input  logic               rst_n_i,
  bus_if.sink                bus,
  input  logic               capture_i,
  output i3c_pkg::bus_byte_t frame_byte_o,
  output logic               byte_done_o,
  output logic               ack_slot_o,
  output i3c_pkg::bus_byte_t rx_data_o,
  output logic               rx_valid_o,
  input  logic               rx_ready_i
);

  localparam i3c_pkg::bit_cnt_t LAST_DATA_BIT = 4'd7;
  localparam i3c_pkg::bit_cnt_t ACK_BIT       = 4'd8;

  i3c_pkg::bit_cnt_t  bit_cnt_q;
  logic [6:0]         shift_q;
  logic               ack_slot_q;
  i3c_pkg::bus_byte_t rx_data_q;
  logic               rx_valid_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      bit_cnt_q  <= '0;
      ack_slot_q <= 1'b0;
    end else if (bus.start || bus.rstart || bus.stop) begin
      bit_cnt_q  <= '0;
      ack_slot_q <= 1'b0;
    end else if (bus.scl_rise && bit_cnt_q != ACK_BIT) begin
      bit_cnt_q <= bit_cnt_q + 1'b1;
    end else if (bus.scl_fall && bit_cnt_q == ACK_BIT) begin
      // First fall opens the ACK slot, second one closes the frame
      if (ack_slot_q) begin
        ack_slot_q <= 1'b0;
        bit_cnt_q  <= '0;
      end else begin
        ack_slot_q <= 1'b1;
      end
    end
  end

  // MSB first; older bits simply fall off the top
  always_ff @(posedge clk_i) begin
    if (bus.scl_rise) begin
      shift_q <= {shift_q[5:0], bus.sda};
    end
  end

  assign frame_byte_o = {shift_q, bus.sda};
  assign byte_done_o  = bus.scl_rise && (bit_cnt_q == LAST_DATA_BIT);
  assign ack_slot_o   = ack_slot_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rx_valid_q <= 1'b0;
    end else if (capture_i) begin
      rx_valid_q <= 1'b1;
    end else if (rx_ready_i) begin
      rx_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (capture_i) begin
      rx_data_q <= frame_byte_o;
    end
  end

  assign rx_data_o  = rx_data_q;
  assign rx_valid_o = rx_valid_q;

endmodule

`default_nettype wire

//--- rtl/bus_monitor.sv
//-------------------------------------------------
// Pin conditioning for SCL and SDA: synchronizer,
// glitch filter, then edge and START/STOP detect.
// Pulses lag the pins by FILTER_CYCLES + 3 cycles.
//-------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module bus_monitor #(
  parameter int unsigned FILTER_CYCLES = i3c_pkg::FILTER_CYCLES_DEFAULT
) (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic scl_i,
  input  logic sda_i,
  bus_if.mon   bus
);

  localparam int unsigned CNT_W = $clog2(FILTER_CYCLES + 1);

  // Bit 1 is SCL, bit 0 is SDA
  logic [1:0]            sync1_q;
  logic [1:0]            sync2_q;
  logic [1:0]            filt_q;
  logic [1:0][CNT_W-1:0] stable_cnt_q;

  logic scl_f;
  logic sda_f;
  logic scl_q;
  logic sda_q;
  logic busy_q;
  logic start_det;
  logic stop_det;

  // Idle bus is pulled high
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sync1_q <= '1;
      sync2_q <= '1;
    end else begin
      sync1_q <= {scl_i, sda_i};
      sync2_q <= sync1_q;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      filt_q       <= '1;
      stable_cnt_q <= '0;
    end else begin
      for (int i = 0; i < 2; i++) begin
        if (sync2_q[i] == filt_q[i]) begin
          stable_cnt_q[i] <= '0;
        end else if (stable_cnt_q[i] == CNT_W'(FILTER_CYCLES - 1)) begin
          filt_q[i]       <= sync2_q[i];
          stable_cnt_q[i] <= '0;
        end else begin
          stable_cnt_q[i] <= stable_cnt_q[i] + 1'b1;
        end
      end
    end
  end

  assign scl_f = filt_q[1];
  assign sda_f = filt_q[0];

  // SDA moving while SCL stays high
  assign start_det = scl_f & scl_q & sda_q & ~sda_f;
  assign stop_det  = scl_f & scl_q & ~sda_q & sda_f;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      scl_q        <= 1'b1;
      sda_q        <= 1'b1;
      busy_q       <= 1'b0;
      bus.scl_rise <= 1'b0;
      bus.scl_fall <= 1'b0;
      bus.start    <= 1'b0;
      bus.rstart   <= 1'b0;
      bus.stop     <= 1'b0;
    end else begin
      scl_q        <= scl_f;
      sda_q        <= sda_f;
      bus.scl_rise <= scl_f & ~scl_q;
      bus.scl_fall <= ~scl_f & scl_q;
      bus.start    <= start_det & ~busy_q;
      bus.rstart   <= start_det & busy_q;
      bus.stop     <= stop_det;
      if (start_det) begin
        busy_q <= 1'b1;
      end else if (stop_det) begin
        busy_q <= 1'b0;
      end
    end
  end

  // Levels aligned with the edge pulses
  assign bus.scl = scl_q;
  assign bus.sda = sda_q;

endmodule

`default_nettype wire

//--- rtl/bus_if.sv
//-------------------------------------------------
// Filtered bus levels and condition pulses, driven
// by the bus monitor and read by its consumers.
//-------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

interface bus_if;

  logic scl;
  logic sda;

  // Single-cycle pulses
  logic scl_rise;
  logic scl_fall;
  logic start;
  logic rstart;
  logic stop;

  modport mon (
    output scl, sda, scl_rise, scl_fall, start, rstart, stop
  );

  modport sink (
    input scl, sda, scl_rise, scl_fall, start, rstart, stop
  );

endinterface

`default_nettype wire

//--- rtl/i3c_pkg.sv
//-------------------------------------------------
// Shared types and defaults for the target-side
// bus path. Referenced with scoped names only.
//-------------------------------------------------
`default_nettype none

package i3c_pkg;

  typedef logic [6:0] addr7_t;

  // Address byte with RnW in bit 0, or a data byte
  typedef logic [7:0] bus_byte_t;

  // Position within the 8 data bits plus ACK
  typedef logic [3:0] bit_cnt_t;

  typedef logic [19:0] hold_cnt_t;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_ADDR,
    ST_ADDR_ACK,
    ST_DATA,
    ST_DATA_ACK,
    ST_WAIT_STOP
  } fsm_state_t;

  // Cycles a pin must be steady before it is accepted
  parameter int unsigned FILTER_CYCLES_DEFAULT = 2;

endpackage

`default_nettype wire
